// File: hdl/copro_pkg.sv
package copro_pkg;

   // ------------------------------------------------------------------------
   // CPU bus widths
   // ------------------------------------------------------------------------

   localparam int addr_w     = 16;
   localparam int data_w     = 16;

   // Internal RAM word address bits, 8K words
   localparam int int_ram_aw = 13;

   // Byte-wide SRAM address width
   localparam int ext_ram_aw = 19;

   // ------------------------------------------------------------------------
   // Memory map and wait states
   // ------------------------------------------------------------------------

   // Tube window FEF8-FEFF, compared on address bits 15:3
   localparam logic [12:0] tube_base_hi = 13'h1FDF;

   // Cycles with clken low during an external access
   localparam int ext_wait_cycles = 7;
   // Cycles per SRAM byte phase, two phases per word
   localparam int ext_byte_cycles = 4;

   // Which target a request goes to
   typedef enum logic [1:0] {
      region_none = 2'd0,
      region_int  = 2'd1,
      region_ext  = 2'd2,
      region_tube = 2'd3
   } bus_region_e;

   // Mailbox registers, offset in the tube window
   typedef enum logic [2:0] {
      mbox_status = 3'd0,
      mbox_data   = 3'd1
   } mbox_reg_e;

   // Status register bit positions
   localparam int mbox_h2p_full_bit = 7;
   localparam int mbox_p2h_free_bit = 6;

endpackage

// File: hdl/cpu_bus_if.sv
`timescale 1ns/1ps

// CPU request side of the bus
// Read data and selects are per target and travel on plain ports
interface cpu_bus_if
   import copro_pkg::*;
();

   // Word address from the CPU
   logic [addr_w-1:0] addr;
   // Write data from the CPU
   logic [data_w-1:0] wdata;
   // High for read, low for write
   logic              rnw;
   // Low while a memory request is presented
   logic              mreq_b;

   // Address decode sees the whole request
   modport decode (
      input addr,
      input wdata,
      input rnw,
      input mreq_b
   );

   // Targets are qualified by their own chip select
   modport target (
      input addr,
      input wdata,
      input rnw
   );

endinterface

// File: hdl/copro_bus_ctrl.sv
`timescale 1ns/1ps

module copro_bus_ctrl
   import copro_pkg::*;
(
   input  logic              clk_cpu,
   input  logic              RSTn_sync,
   cpu_bus_if.decode         bus,
   output logic              int_cs_b,
   output logic              ext_cs_b,
   output logic              tube_cs_b,
   input  logic [15:0]       int_rdata,
   input  logic [15:0]       ext_rdata,
   input  logic [7:0]        tube_rdata,
   output logic [15:0]       cpu_din,
   input  logic              irq_req_n,
   output logic              cpu_int_b
);

   bus_region_e region;
   logic        irq_meta_n;

   // ------------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------------

   // Tube window sits inside F000-FFFF, so it is checked first
   always_comb
   begin
      if (bus.mreq_b)
         region = region_none;
      else if (bus.addr[15:3] == tube_base_hi)
         region = region_tube;
      else if (bus.addr[15:12] == 4'h0 || bus.addr[15:12] == 4'hF)
         region = region_int;
      else
         region = region_ext;
   end

   // One active-low select per target
   assign int_cs_b  = (region != region_int);
   assign ext_cs_b  = (region != region_ext);
   assign tube_cs_b = (region != region_tube);

   // Read data steering, external RAM when nothing else is selected
   always_comb
   begin
      case (region)
         region_tube: cpu_din = {8'h00, tube_rdata};
         region_int:  cpu_din = int_rdata;
         default:     cpu_din = ext_rdata;
      endcase
   end

   // ------------------------------------------------------------------------
   // Interrupt synchronizer
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_cpu)
   begin
      if (!RSTn_sync)
      begin
         irq_meta_n <= 1'b1;
         cpu_int_b  <= 1'b1;
      end
      else
      begin
         irq_meta_n <= irq_req_n;
         cpu_int_b  <= irq_meta_n;
      end
   end

endmodule

// File: hdl/copro_int_ram.sv
`timescale 1ns/1ps

module copro_int_ram
   import copro_pkg::*;
(
   input  logic              clk_cpu,
   cpu_bus_if.target         bus,
   input  logic              cs_b,
   output logic [15:0]       rdata
);

   localparam int depth = 1 << int_ram_aw;

   logic [data_w-1:0]     mem [0:depth-1];
   logic [int_ram_aw-1:0] word_addr;

   // Bits 15:12 dropped, so the F000 window aliases the 0000 window
   assign word_addr = {1'b0, bus.addr[int_ram_aw-2:0]};

   // ------------------------------------------------------------------------
   // Falling edge access
   // ------------------------------------------------------------------------

   // Address is stable half a cycle after the rising edge
   // Data is back before the next rising edge, so no wait states
   always_ff @(negedge clk_cpu)
   begin
      if (!cs_b)
      begin
         if (!bus.rnw)
            mem[word_addr] <= bus.wdata;
         else
            rdata <= mem[word_addr];
      end
   end

endmodule

// File: hdl/copro_ext_mem_ctrl.sv
`timescale 1ns/1ps

module copro_ext_mem_ctrl
   import copro_pkg::*;
(
   input  logic                  clk_cpu,
   input  logic                  RSTn_sync,
   cpu_bus_if.target             bus,
   input  logic                  cs_b,
   output logic                  clken,
   output logic [15:0]           rdata,
   output logic                  ram_cs_b,
   output logic                  ram_oe_b,
   output logic                  ram_we_b,
   output logic [18:0]           ram_addr,
   inout  wire  [7:0]            ram_data
);

   logic [2:0] count;
   logic       byte_hi;
   logic       we_next;
   logic [7:0] low_byte;
   logic [7:0] wr_byte;

   // ------------------------------------------------------------------------
   // Wait-state counter
   // ------------------------------------------------------------------------

   // Counts 0..7 across one external access
   // Wraps back to 0 at count 7, so a new access can start at once
   always_ff @(posedge clk_cpu)
   begin
      if (!RSTn_sync)
         count <= 3'd0;
      else if (!cs_b || count != 3'd0)
         count <= count + 3'd1;
   end

   // CPU stalls for counts 0 to 6 and completes at count 7
   assign clken = !(!cs_b && count < ext_wait_cycles);

   // Low byte in counts 0-3, high byte in counts 4-7
   assign byte_hi = (count >= ext_byte_cycles);

   // ------------------------------------------------------------------------
   // Write strobe
   // ------------------------------------------------------------------------

   // Strobe is low for the second and third cycle of each byte phase
   // One cycle of address and data setup ahead, one of hold after
   always_comb
   begin
      we_next = 1'b0;
      if (!bus.rnw)
      begin
         if (count == 3'd0 && !cs_b)
            we_next = 1'b1;
         else if (count == 3'd1)
            we_next = 1'b1;
         else if (count == ext_byte_cycles)
            we_next = 1'b1;
         else if (count == ext_byte_cycles + 1)
            we_next = 1'b1;
      end
   end

   // Registered so the SRAM never sees a glitch on WE
   always_ff @(posedge clk_cpu)
   begin
      if (!RSTn_sync)
         ram_we_b <= 1'b1;
      else
         ram_we_b <= !we_next;
   end

   // ------------------------------------------------------------------------
   // Read data
   // ------------------------------------------------------------------------

   // Low byte held from the end of the first phase
   always_ff @(posedge clk_cpu)
   begin
      if (count == ext_byte_cycles - 1)
         low_byte <= ram_data;
   end

   // High byte comes straight from the pins at count 7
   assign rdata = {ram_data, low_byte};

   // ------------------------------------------------------------------------
   // SRAM pins
   // ------------------------------------------------------------------------

   // Byte address is the word address with the phase bit appended
   assign ram_addr = {{(ext_ram_aw - addr_w - 1){1'b0}}, bus.addr, byte_hi};
   assign ram_cs_b = cs_b;
   // Output enable only on reads, so pins are free for write data
   assign ram_oe_b = cs_b | !bus.rnw;

   assign wr_byte  = byte_hi ? bus.wdata[15:8] : bus.wdata[7:0];
   assign ram_data = (!cs_b && !bus.rnw) ? wr_byte : 8'bz;

endmodule

// File: hdl/copro_mailbox.sv
`timescale 1ns/1ps

module copro_mailbox
   import copro_pkg::*;
(
   input  logic              clk_cpu,
   input  logic              RSTn_sync,
   cpu_bus_if.target         bus,
   input  logic              cs_b,
   output logic [7:0]        rdata,
   input  logic              host_wr_stb,
   input  logic [7:0]        host_wr_data,
   input  logic              host_rd_stb,
   output logic [7:0]        host_rd_data,
   output logic              host_data_avail,
   output logic              irq_req_n
);

   mbox_reg_e  reg_sel;
   logic       p_rd_data;
   logic       p_wr_data;
   logic [7:0] h2p_data;
   logic       h2p_full;
   logic [7:0] p2h_data;
   logic       p2h_full;
   logic [7:0] status;

   // Register offset within the tube window
   assign reg_sel   = mbox_reg_e'(bus.addr[2:0]);

   // Parasite accesses to the data register
   assign p_rd_data = !cs_b && bus.rnw && (reg_sel == mbox_data);
   assign p_wr_data = !cs_b && !bus.rnw && (reg_sel == mbox_data);

   // ------------------------------------------------------------------------
   // Host to parasite
   // ------------------------------------------------------------------------

   // A host write while full just overwrites, flag stays set
   always_ff @(posedge clk_cpu)
   begin
      if (host_wr_stb)
         h2p_data <= host_wr_data;
   end

   // Host write wins over a parasite read in the same cycle
   always_ff @(posedge clk_cpu)
   begin
      if (!RSTn_sync)
         h2p_full <= 1'b0;
      else if (host_wr_stb)
         h2p_full <= 1'b1;
      else if (p_rd_data)
         h2p_full <= 1'b0;
   end

   // Interrupt held while the host byte is unread
   assign irq_req_n = !h2p_full;

   // ------------------------------------------------------------------------
   // Parasite to host
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_cpu)
   begin
      if (p_wr_data)
         p2h_data <= bus.wdata[7:0];
   end

   // Parasite write wins over a host read in the same cycle
   always_ff @(posedge clk_cpu)
   begin
      if (!RSTn_sync)
         p2h_full <= 1'b0;
      else if (p_wr_data)
         p2h_full <= 1'b1;
      else if (host_rd_stb)
         p2h_full <= 1'b0;
   end

   assign host_rd_data    = p2h_data;
   assign host_data_avail = p2h_full;

   // Parasite read mux, unused offsets read zero
   always_comb
   begin
      status                    = 8'h00;
      status[mbox_h2p_full_bit] = h2p_full;
      status[mbox_p2h_free_bit] = !p2h_full;
      case (reg_sel)
         mbox_status: rdata = status;
         mbox_data:   rdata = h2p_data;
         default:     rdata = 8'h00;
      endcase
   end

endmodule

// File: hdl/copro_top.sv
`timescale 1ns/1ps

module copro_top (
   input  logic          clk_cpu,
   input  logic          RSTn_sync,
   // CPU bus
   input  logic [15:0]   cpu_addr,
   input  logic [15:0]   cpu_dout,
   input  logic          cpu_rnw,
   input  logic          cpu_mreq_b,
   output logic [15:0]   cpu_din,
   output logic          cpu_clken,
   output logic          cpu_int_b,
   // Byte-wide SRAM
   output logic          ram_cs_b,
   output logic          ram_oe_b,
   output logic          ram_we_b,
   output logic [18:0]   ram_addr,
   inout  wire  [7:0]    ram_data,
   // Host side of the mailbox
   input  logic          host_wr_stb,
   input  logic [7:0]    host_wr_data,
   input  logic          host_rd_stb,
   output logic [7:0]    host_rd_data,
   output logic          host_data_avail
);

   logic        int_cs_b;
   logic        ext_cs_b;
   logic        tube_cs_b;
   logic [15:0] int_rdata;
   logic [15:0] ext_rdata;
   logic [7:0]  tube_rdata;
   logic        irq_req_n;

   // ------------------------------------------------------------------------
   // CPU request bundle
   // ------------------------------------------------------------------------

   cpu_bus_if bus ();

   assign bus.addr   = cpu_addr;
   assign bus.wdata  = cpu_dout;
   assign bus.rnw    = cpu_rnw;
   assign bus.mreq_b = cpu_mreq_b;

   // Decode, read mux and interrupt sync
   copro_bus_ctrl copro_bus_ctrl_inst (
      .clk_cpu    (clk_cpu),
      .RSTn_sync  (RSTn_sync),
      .bus        (bus.decode),
      .int_cs_b   (int_cs_b),
      .ext_cs_b   (ext_cs_b),
      .tube_cs_b  (tube_cs_b),
      .int_rdata  (int_rdata),
      .ext_rdata  (ext_rdata),
      .tube_rdata (tube_rdata),
      .cpu_din    (cpu_din),
      .irq_req_n  (irq_req_n),
      .cpu_int_b  (cpu_int_b)
   );

   copro_int_ram copro_int_ram_inst (
      .clk_cpu (clk_cpu),
      .bus     (bus.target),
      .cs_b    (int_cs_b),
      .rdata   (int_rdata)
   );

   // Only source of clken stalls
   copro_ext_mem_ctrl copro_ext_mem_ctrl_inst (
      .clk_cpu   (clk_cpu),
      .RSTn_sync (RSTn_sync),
      .bus       (bus.target),
      .cs_b      (ext_cs_b),
      .clken     (cpu_clken),
      .rdata     (ext_rdata),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b),
      .ram_addr  (ram_addr),
      .ram_data  (ram_data)
   );

   copro_mailbox copro_mailbox_inst (
      .clk_cpu         (clk_cpu),
      .RSTn_sync       (RSTn_sync),
      .bus             (bus.target),
      .cs_b            (tube_cs_b),
      .rdata           (tube_rdata),
      .host_wr_stb     (host_wr_stb),
      .host_wr_data    (host_wr_data),
      .host_rd_stb     (host_rd_stb),
      .host_rd_data    (host_rd_data),
      .host_data_avail (host_data_avail),
      .irq_req_n       (irq_req_n)
   );

endmodule

// File: bench/ext_ram_model.sv
`timescale 1ns/1ps

// Byte-wide asynchronous SRAM, behavioral
module ext_ram_model
   import copro_pkg::*;
(
   input  logic                  ram_cs_b,
   input  logic                  ram_oe_b,
   input  logic                  ram_we_b,
   input  logic [ext_ram_aw-1:0] ram_addr,
   inout  wire  [7:0]            ram_data
);

   localparam int depth = 1 << ext_ram_aw;

   // Byte array, also peeked at by the testbench
   logic [7:0] mem [0:depth-1];

   // ------------------------------------------------------------------------
   // Read path
   // ------------------------------------------------------------------------

   // Pins driven only for a read cycle with WE high
   assign ram_data = (!ram_cs_b && !ram_oe_b && ram_we_b) ? mem[ram_addr] : 8'bz;

   // ------------------------------------------------------------------------
   // Write path
   // ------------------------------------------------------------------------

   // Level-sensitive write while CS and WE are both low
   // Last value before WE rises is what stays in the array
   always @(ram_cs_b or ram_we_b or ram_addr or ram_data)
   begin
      if (!ram_cs_b && !ram_we_b)
         mem[ram_addr] = ram_data;
   end

endmodule

// File: bench/copro_properties.sv
`timescale 1ns/1ps

module copro_properties
   import copro_pkg::*;
(
   input logic        clk_cpu,
   input logic        RSTn_sync,
   input logic [15:0] cpu_addr,
   input logic        cpu_mreq_b,
   input logic        cpu_rnw,
   input logic        cpu_clken,
   input logic        cpu_int_b,
   input logic        ram_cs_b,
   input logic        ram_oe_b,
   input logic        ram_we_b,
   input logic        irq_req_n
);

   // Number of failed property checks so far
   int failures = 0;

   // ------------------------------------------------------------------------
   // External access stall
   // ------------------------------------------------------------------------

   // Stall starts at count 0 and ends with clken high at count 7
   stall_length: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      $fell(cpu_clken) |-> !cpu_clken [*ext_wait_cycles] ##1 cpu_clken)
   else
   begin
      $error("cpu_clken low for other than %0d cycles", ext_wait_cycles);
      failures++;
   end

   // Internal RAM and mailbox never stall
   // 0000-0FFF and F000-FFFF, the tube window sits inside the top one
   zero_wait: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      (!cpu_mreq_b && (cpu_addr[15:12] == 4'h0 || cpu_addr[15:12] == 4'hF))
         |-> cpu_clken)
   else
   begin
      $error("cpu_clken low during an internal or mailbox access");
      failures++;
   end

   // ------------------------------------------------------------------------
   // Write strobe and output enable
   // ------------------------------------------------------------------------

   // WE low only in counts 1, 2, 5 and 6 of a write
   write_strobe: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      $fell(cpu_clken) && !cpu_rnw |->
         ram_we_b ##1 !ram_we_b [*2] ##1 ram_we_b [*2] ##1 !ram_we_b [*2] ##1 ram_we_b)
   else
   begin
      $error("ram_we_b pattern wrong during an external write");
      failures++;
   end

   // WE only pulses inside a selected access, with the SRAM outputs off
   write_oe_off: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      !ram_we_b |-> !ram_cs_b && ram_oe_b)
   else
   begin
      $error("ram_we_b low outside an external access or with ram_oe_b low");
      failures++;
   end

   // Reads never strobe WE
   read_no_we: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      (!ram_cs_b && cpu_rnw) |-> ram_we_b)
   else
   begin
      $error("ram_we_b low during an external read");
      failures++;
   end

   // ------------------------------------------------------------------------
   // Interrupt synchronizer
   // ------------------------------------------------------------------------

   int_assert: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      $fell(irq_req_n) |-> ##2 $fell(cpu_int_b))
   else
   begin
      $error("cpu_int_b did not fall 2 cycles after irq_req_n");
      failures++;
   end

   int_release: assert property (@(posedge clk_cpu) disable iff (!RSTn_sync)
      $rose(irq_req_n) |-> ##2 $rose(cpu_int_b))
   else
   begin
      $error("cpu_int_b did not rise 2 cycles after irq_req_n");
      failures++;
   end

endmodule

// Top level sees both the SRAM pins and the interrupt path
bind copro_top copro_properties copro_properties_inst (
   .clk_cpu    (clk_cpu),
   .RSTn_sync  (RSTn_sync),
   .cpu_addr   (cpu_addr),
   .cpu_mreq_b (cpu_mreq_b),
   .cpu_rnw    (cpu_rnw),
   .cpu_clken  (cpu_clken),
   .cpu_int_b  (cpu_int_b),
   .ram_cs_b   (ram_cs_b),
   .ram_oe_b   (ram_oe_b),
   .ram_we_b   (ram_we_b),
   .irq_req_n  (irq_req_n)
);

// File: bench/copro_tb.sv
`timescale 1ns/1ps

module copro_tb
   import copro_pkg::*;
();

   localparam int clk_period = 8;
   localparam int drive_dly  = 1;
   localparam int int_words  = 8;
   localparam int ext_words  = 8;
   localparam int mbox_ops   = 7;
   localparam int random_ops = 200;
   localparam int max_wait   = 20;
   // Internal words are written once and read at both windows
   localparam int planned_ops = int_words * 3 + ext_words * 2 + mbox_ops + random_ops;
   localparam int watchdog_cycles = planned_ops * max_wait + 200;

   // Mailbox register addresses in the tube window
   localparam logic [15:0] mbox_status_addr = {tube_base_hi, mbox_status};
   localparam logic [15:0] mbox_data_addr   = {tube_base_hi, mbox_data};

   logic        clk_cpu;
   logic        RSTn_sync;
   logic [15:0] cpu_addr;
   logic [15:0] cpu_dout;
   logic        cpu_rnw;
   logic        cpu_mreq_b;
   logic [15:0] cpu_din;
   logic        cpu_clken;
   logic        cpu_int_b;
   logic        ram_cs_b;
   logic        ram_oe_b;
   logic        ram_we_b;
   logic [18:0] ram_addr;
   wire  [7:0]  ram_data;
   logic        host_wr_stb;
   logic [7:0]  host_wr_data;
   logic        host_rd_stb;
   logic [7:0]  host_rd_data;
   logic        host_data_avail;

   integer      seed = 32'hfe75;
   // Reference memory, indexed by address with the F000 alias folded down
   logic [15:0] ref_mem [0:65535];
   // Addresses that hold a known word
   logic [15:0] written [$];

   copro_top copro_top_inst (.*);

   ext_ram_model ext_ram_model_inst (
      .ram_cs_b (ram_cs_b),
      .ram_oe_b (ram_oe_b),
      .ram_we_b (ram_we_b),
      .ram_addr (ram_addr),
      .ram_data (ram_data)
   );

   initial
   begin
      clk_cpu = 1'b0;
      forever
         #(clk_period / 2) clk_cpu = ~clk_cpu;
   end

   // ------------------------------------------------------------------------
   // Checking helpers
   // ------------------------------------------------------------------------

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      assert (actual === expected)
      else
      begin
         $display("mismatch %s expected %h actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   // F000-FFFF shares storage with 0000-0FFF
   function automatic int ref_index(input logic [15:0] addr);
      if (addr[15:12] == 4'hF)
         return int'(addr[11:0]);
      return int'(addr);
   endfunction

   // Status byte as the mailbox should report it
   function automatic logic [15:0] status_word(input logic h2p_full, input logic p2h_full);
      logic [15:0] s;
      s                    = 16'h0000;
      s[mbox_h2p_full_bit] = h2p_full;
      s[mbox_p2h_free_bit] = !p2h_full;
      return s;
   endfunction

   // Region 0 low window, 1 high window, else external
   function automatic logic [15:0] pick_addr(input int region);
      logic [15:0] addr;
      addr = 16'($random(seed));
      if (region == 0)
         addr[15:12] = 4'h0;
      else if (region == 1)
         addr[15:12] = 4'hF;
      else
         addr[15:12] = 4'(4'h1 + $unsigned($random(seed)) % 14);
      // Stay clear of the tube window and its alias in the low window
      if (addr[11:3] == tube_base_hi[8:0])
         addr[3] = 1'b0;
      return addr;
   endfunction

   // ------------------------------------------------------------------------
   // CPU bus and host tasks
   // ------------------------------------------------------------------------

   // Entered and left just after a rising edge
   task automatic cpu_access(input logic rnw, input logic [15:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
      int   cycles;
      logic done;
      cycles     = 0;
      done       = 1'b0;
      cpu_addr   = addr;
      cpu_dout   = wdata;
      cpu_rnw    = rnw;
      cpu_mreq_b = 1'b0;
      while (!done)
      begin
         // Outputs settle by the falling edge, sample well before the rising one
         @(negedge clk_cpu);
         #drive_dly;
         done  = cpu_clken;
         rdata = cpu_din;
         cycles++;
         @(posedge clk_cpu);
         #drive_dly;
         if (!done && cycles >= max_wait)
         begin
            $display("CPU access to %h never completed", addr);
            abort_run();
         end
      end
      cpu_mreq_b = 1'b1;
      cpu_rnw    = 1'b1;
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [15:0] data);
      logic [15:0] unused;
      cpu_access(1'b0, addr, data, unused);
      ref_mem[ref_index(addr)] = data;
   endtask

   task automatic read_expect(input string name, input logic [15:0] addr,
                              input logic [15:0] expected);
      logic [15:0] data;
      cpu_access(1'b1, addr, 16'h0000, data);
      check_word(name, expected, data);
   endtask

   task automatic host_write(input logic [7:0] data);
      host_wr_data = data;
      host_wr_stb  = 1'b1;
      @(posedge clk_cpu);
      #drive_dly;
      host_wr_stb  = 1'b0;
   endtask

   task automatic host_read(output logic [7:0] data);
      data        = host_rd_data;
      host_rd_stb = 1'b1;
      @(posedge clk_cpu);
      #drive_dly;
      host_rd_stb = 1'b0;
   endtask

   task automatic wait_int(input logic level);
      int cycles;
      cycles = 0;
      while (cpu_int_b !== level && cycles < max_wait)
      begin
         @(posedge clk_cpu);
         #drive_dly;
         cycles++;
      end
      check_word("cpu_int_b", {15'd0, level}, {15'd0, cpu_int_b});
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial
   begin : main
      logic [15:0] addr;
      logic [15:0] data;
      logic [7:0]  byte_out;
      cpu_addr     = 16'h0000;
      cpu_dout     = 16'h0000;
      cpu_rnw      = 1'b1;
      cpu_mreq_b   = 1'b1;
      host_wr_stb  = 1'b0;
      host_wr_data = 8'h00;
      host_rd_stb  = 1'b0;
      RSTn_sync    = 1'b0;
      repeat (5) @(posedge clk_cpu);
      #drive_dly;
      RSTn_sync = 1'b1;
      @(posedge clk_cpu);
      #drive_dly;

      // Internal RAM, both windows, then each word through its alias
      for (int i = 0; i < int_words; i++)
      begin
         addr = pick_addr(i % 2);
         cpu_write(addr, 16'($random(seed)));
         written.push_back(addr);
      end
      for (int i = 0; i < int_words; i++)
      begin
         read_expect("int_ram", written[i], ref_mem[ref_index(written[i])]);
         read_expect("int_alias", written[i] ^ 16'hF000, ref_mem[ref_index(written[i])]);
      end

      // External RAM, low byte at the even SRAM address
      for (int i = 0; i < ext_words; i++)
      begin
         addr = pick_addr(2);
         data = 16'($random(seed));
         cpu_write(addr, data);
         written.push_back(addr);
         check_word("sram_low", {8'h00, data[7:0]},
                    {8'h00, ext_ram_model_inst.mem[int'(addr) * 2]});
         check_word("sram_high", {8'h00, data[15:8]},
                    {8'h00, ext_ram_model_inst.mem[int'(addr) * 2 + 1]});
      end
      // Back-to-back reads
      for (int i = int_words; i < int_words + ext_words; i++)
         read_expect("ext_ram", written[i], ref_mem[ref_index(written[i])]);

      // Host to parasite
      read_expect("status_idle", mbox_status_addr, status_word(1'b0, 1'b0));
      byte_out = 8'($random(seed));
      host_write(byte_out);
      read_expect("status_h2p_full", mbox_status_addr, status_word(1'b1, 1'b0));
      wait_int(1'b0);
      read_expect("h2p_data", mbox_data_addr, {8'h00, byte_out});
      read_expect("status_h2p_taken", mbox_status_addr, status_word(1'b0, 1'b0));
      wait_int(1'b1);

      // Parasite to host
      data = 16'($random(seed));
      cpu_write(mbox_data_addr, data);
      check_word("host_data_avail", 16'h0001, {15'd0, host_data_avail});
      read_expect("status_p2h_full", mbox_status_addr, status_word(1'b0, 1'b1));
      host_read(byte_out);
      check_word("host_rd_data", {8'h00, data[7:0]}, {8'h00, byte_out});
      check_word("host_data_taken", 16'h0000, {15'd0, host_data_avail});
      read_expect("status_p2h_free", mbox_status_addr, status_word(1'b0, 1'b0));

      // Random mix, reads only from addresses with a known word
      for (int i = 0; i < random_ops; i++)
      begin
         if ($random(seed) & 1)
         begin
            addr = written[$unsigned($random(seed)) % written.size()];
            read_expect("random_read", addr, ref_mem[ref_index(addr)]);
         end
         else
         begin
            addr = pick_addr($unsigned($random(seed)) % 3);
            cpu_write(addr, 16'($random(seed)));
            written.push_back(addr);
         end
      end

      // Let the last properties finish
      repeat (4) @(posedge clk_cpu);
      if (copro_top_inst.copro_properties_inst.failures == 0)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
      begin
         $display("bound property checks failed");
         abort_run();
      end
   end

   // Stop at the first failed property
   initial
   begin
      wait (copro_top_inst.copro_properties_inst.failures != 0);
      $display("a bound property check failed, see the error above");
      abort_run();
   end

   // Watchdog
   initial
   begin
      #(watchdog_cycles * clk_period);
      $display("timeout, run did not finish within %0d cycles", watchdog_cycles);
      abort_run();
   end

endmodule

// File: filelist.f
hdl/copro_pkg.sv
hdl/cpu_bus_if.sv
hdl/copro_bus_ctrl.sv
hdl/copro_int_ram.sv
hdl/copro_ext_mem_ctrl.sv
hdl/copro_mailbox.sv
hdl/copro_top.sv
bench/ext_ram_model.sv
bench/copro_properties.sv
bench/copro_tb.sv
